//--- hist_builder_top.f
+incdir+logic
logic/hist_pkg.sv
logic/hist_config_regs.sv
logic/hist_sequencer.sv
logic/hist_bank.sv
logic/hist_readout.sv
logic/hist_builder_top.sv
dv/hist_builder_properties.sv
dv/hist_builder_tb.sv

//--- Makefile
# Verilator flow for the histogram builder

TOP := hist_builder_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f hist_builder_top.f

# a $fatal or a failed assertion gives a nonzero exit status
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f hist_builder_top.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- dv/hist_builder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_cfg.svh"

module hist_builder_tb;

    localparam int BINS   = `HIST_BINS;
    localparam int PIXELS = `HIST_PIXELS;
    localparam int WORDS  = BINS * PIXELS;
    // hits: config, random, saturation, ping-pong, clear-on-read, reset
    localparam int TOTAL_HITS  = 12 + 16 + 1280 + 32 + 48 + 23;
    // nine banks streamed over all tests
    localparam int READ_ITEMS  = 9 * WORDS;
    localparam int CYCLE_LIMIT = 2 * (TOTAL_HITS + 5 * READ_ITEMS);

    logic                 clk;
    logic                 combin_res;
    logic                 hit_valid;
    hist_pkg::bin_idx_t   hit_bin;
    logic                 hit_ready;
    logic                 cfg_req;
    hist_pkg::cfg_addr_e  cfg_addr;
    logic [15:0]          cfg_data;
    logic                 cfg_ack;
    logic                 rd_req;
    logic                 rd_ack;
    hist_pkg::pixel_idx_t rd_pixel;
    hist_pkg::bin_idx_t   rd_bin;
    hist_pkg::bin_count_t rd_count;
    logic                 rd_bank;
    logic                 frame_done;

    // reference model, bank then pixel then bin
    hist_pkg::bin_count_t model [2][PIXELS][BINS];
    hist_pkg::bin_count_t last_read [PIXELS][BINS];
    hist_pkg::bin_count_t first_read [PIXELS][BINS];
    // completed banks waiting for readout, oldest first
    logic rd_q [$];
    int   m_hit;
    int   m_pix;
    int   m_acq;
    logic m_fill;
    int   cfg_hits;
    int   cfg_acq;
    int   cycles = 0;

    hist_builder_top u_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .hit_ready  (hit_ready),
        .cfg_req    (cfg_req),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .cfg_ack    (cfg_ack),
        .rd_req     (rd_req),
        .rd_ack     (rd_ack),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .rd_bank    (rd_bank),
        .frame_done (frame_done)
    );

    always #2 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic report_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_count(input hist_pkg::bin_count_t got, input hist_pkg::bin_count_t exp,
                               input string what);
        if (got !== exp)
            report_failure($sformatf("%s count %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_position(input hist_pkg::pixel_idx_t got_p,
                                  input hist_pkg::bin_idx_t got_b,
                                  input hist_pkg::pixel_idx_t exp_p,
                                  input hist_pkg::bin_idx_t exp_b);
        if (got_p !== exp_p || got_b !== exp_b)
            report_failure($sformatf("item at pixel %0d bin %0d, expected pixel %0d bin %0d",
                                     got_p, got_b, exp_p, exp_b));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic int frame_hits();
        return cfg_hits * PIXELS * cfg_acq;
    endfunction

    // reset both the DUT and the model
    task automatic apply_reset;
        hit_valid = 1'b0;
        cfg_req   = 1'b0;
        rd_ack    = 1'b0;
        @(negedge clk);
        combin_res = 1'b0;
        repeat (10) @(negedge clk);
        foreach (model[k, p, b]) model[k][p][b] = '0;
        rd_q.delete();
        m_hit    = 0;
        m_pix    = 0;
        m_acq    = 0;
        m_fill   = 1'b0;
        cfg_hits = `HIST_HITS_DEFAULT;
        cfg_acq  = `HIST_ACQ_DEFAULT;
        combin_res = 1'b1;
    endtask

    // four-phase write, ack edges one cycle after req edges
    task automatic write_cfg(input hist_pkg::cfg_addr_e addr, input logic [15:0] data);
        @(negedge clk);
        cfg_addr = addr;
        cfg_data = data;
        cfg_req  = 1'b1;
        @(negedge clk);
        check_flag(cfg_ack, 1'b1, "cfg_ack one cycle after cfg_req rose");
        cfg_req = 1'b0;
        @(negedge clk);
        check_flag(cfg_ack, 1'b0, "cfg_ack one cycle after cfg_req fell");
        if (addr == hist_pkg::CFG_HITS) cfg_hits = data[7:0];
        else cfg_acq = data;
    endtask

    // nested hit, pixel and acquisition counting with saturation
    task automatic model_accept(input hist_pkg::bin_idx_t bin);
        if (model[m_fill][m_pix][bin] != '1) model[m_fill][m_pix][bin]++;
        if (m_hit + 1 < cfg_hits) begin
            m_hit++;
        end else begin
            m_hit = 0;
            if (m_pix < PIXELS - 1) begin
                m_pix++;
            end else begin
                m_pix = 0;
                if (m_acq + 1 < cfg_acq) begin
                    m_acq++;
                end else begin
                    // frame complete, bank queued and fill side flips
                    m_acq = 0;
                    rd_q.push_back(m_fill);
                    m_fill = ~m_fill;
                end
            end
        end
    endtask

    task automatic send_hit(input hist_pkg::bin_idx_t bin);
        @(negedge clk);
        hit_valid = 1'b1;
        hit_bin   = bin;
        while (!hit_ready) @(negedge clk);
        // taken on the edge just passed
        @(negedge clk);
        hit_valid = 1'b0;
        model_accept(bin);
    endtask

    // reactive sink, one whole bank in address order
    task automatic read_frame;
        logic                 bank;
        hist_pkg::pixel_idx_t p;
        hist_pkg::bin_idx_t   b;
        bank = rd_q.pop_front();
        for (int i = 0; i < WORDS; i++) begin
            p = hist_pkg::pixel_idx_t'(i / BINS);
            b = hist_pkg::bin_idx_t'(i % BINS);
            @(negedge clk);
            while (!rd_req) @(negedge clk);
            check_position(rd_pixel, rd_bin, p, b);
            check_count(rd_count, model[bank][p][b], "streamed bin");
            check_flag(rd_bank, bank, "rd_bank");
            last_read[p][b] = rd_count;
            // bin empties once acknowledged
            model[bank][p][b] = '0;
            rd_ack = 1'b1;
            @(negedge clk);
            check_flag(rd_req, 1'b0, "rd_req one cycle after rd_ack");
            rd_ack = 1'b0;
        end
        @(negedge clk);
        check_flag(frame_done, 1'b1, "frame_done after the last item");
    endtask

    task automatic test_config;
        apply_reset();
        write_cfg(hist_pkg::CFG_HITS, 16'd3);
        write_cfg(hist_pkg::CFG_ACQ, 16'd1);
        for (int i = 0; i < 12; i++) begin
            check_flag(rd_req, 1'b0, "rd_req before the frame is full");
            send_hit(hist_pkg::bin_idx_t'(i));
        end
        // req two edges after the last accepted hit
        check_flag(rd_req, 1'b0, "rd_req one cycle after the last hit");
        @(negedge clk);
        check_flag(rd_req, 1'b0, "rd_req during readout setup");
        @(negedge clk);
        check_flag(rd_req, 1'b1, "rd_req two cycles after the last hit");
        read_frame();
    endtask

    task automatic test_random_frame;
        apply_reset();
        repeat (frame_hits()) send_hit(hist_pkg::bin_idx_t'($urandom % BINS));
        read_frame();
    endtask

    task automatic test_saturation;
        apply_reset();
        write_cfg(hist_pkg::CFG_HITS, 16'd80);
        write_cfg(hist_pkg::CFG_ACQ, 16'd4);
        repeat (frame_hits()) send_hit(hist_pkg::bin_idx_t'(5));
        read_frame();
        foreach (last_read[p, b])
            check_count(last_read[p][b], (b == 5) ? '1 : '0, "saturated bank");
    endtask

    task automatic test_ping_pong;
        apply_reset();
        // sink stays silent while two frames arrive
        repeat (2 * frame_hits()) send_hit(hist_pkg::bin_idx_t'($urandom % BINS));
        repeat (3) begin
            check_flag(hit_ready, 1'b0, "hit_ready with both banks full");
            @(negedge clk);
        end
        read_frame();
        check_flag(hit_ready, 1'b1, "hit_ready after the first frame_done");
        read_frame();
    endtask

    // fixed bin pattern, k picks the stride
    task automatic send_pattern(input int k);
        for (int i = 0; i < frame_hits(); i++)
            send_hit(hist_pkg::bin_idx_t'((i * k + 3) % BINS));
    endtask

    task automatic test_clear_on_read;
        apply_reset();
        send_pattern(7);
        read_frame();
        first_read = last_read;
        // other bank in between so the pattern lands in bank 0 again
        send_pattern(5);
        read_frame();
        send_pattern(7);
        read_frame();
        foreach (last_read[p, b])
            check_count(last_read[p][b], first_read[p][b], "refilled bank");
    endtask

    task automatic test_reset_mid_frame;
        apply_reset();
        repeat (7) send_hit(hist_pkg::bin_idx_t'($urandom % BINS));
        apply_reset();
        repeat (frame_hits()) send_hit(hist_pkg::bin_idx_t'($urandom % BINS));
        read_frame();
    endtask

    initial begin
        void'($urandom(46));
        clk        = 1'b0;
        combin_res = 1'b0;
        hit_valid  = 1'b0;
        hit_bin    = '0;
        cfg_req    = 1'b0;
        cfg_addr   = hist_pkg::CFG_HITS;
        cfg_data   = '0;
        rd_ack     = 1'b0;
        test_config();
        test_random_frame();
        test_saturation();
        test_ping_pong();
        test_clear_on_read();
        test_reset_mid_frame();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/hist_builder_properties.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_properties (
    input wire logic                 clk,
    input wire logic                 combin_res,
    input wire logic                 cfg_req,
    input wire logic                 cfg_ack,
    input wire logic                 rd_req,
    input wire logic                 rd_ack,
    input wire hist_pkg::pixel_idx_t rd_pixel,
    input wire hist_pkg::bin_idx_t   rd_bin,
    input wire hist_pkg::bin_count_t rd_count,
    input wire logic                 rd_bank,
    input wire logic                 frame_done,
    input wire logic                 hit_ready,
    input wire logic                 frame_full,
    input wire logic                 readout_busy
);

    // item stays up with the same payload until the sink answers
    rd_req_hold: assert property (@(posedge clk) disable iff (!combin_res)
        rd_req && !rd_ack |=> rd_req && $stable(rd_pixel) && $stable(rd_bin)
            && $stable(rd_count) && $stable(rd_bank))
        else $error("rd_req fell or its payload moved before rd_ack");

    // ack only in answer to a request
    cfg_ack_cause: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without cfg_req");

    // back-pressure starts only from a frame that completed into a busy readout
    hit_stall_cause: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(hit_ready) |-> frame_full && readout_busy)
        else $error("hit_ready fell without a frame completing during readout");

    // and lasts until the streamed bank is done
    hit_stall_release: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(hit_ready) |-> frame_done)
        else $error("hit_ready rose without frame_done");

endmodule

bind hist_builder_top hist_builder_properties u_props (
    .clk          (clk),
    .combin_res   (combin_res),
    .cfg_req      (cfg_req),
    .cfg_ack      (cfg_ack),
    .rd_req       (rd_req),
    .rd_ack       (rd_ack),
    .rd_pixel     (rd_pixel),
    .rd_bin       (rd_bin),
    .rd_count     (rd_count),
    .rd_bank      (rd_bank),
    .frame_done   (frame_done),
    .hit_ready    (hit_ready),
    .frame_full   (frame_full),
    .readout_busy (readout_busy)
);

`default_nettype wire

//--- logic/hist_builder_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_top (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    // hit port, valid/ready
    input  wire logic                   hit_valid,
    input  wire hist_pkg::bin_idx_t     hit_bin,
    output logic                        hit_ready,
    // configuration port, four-phase
    input  wire logic                   cfg_req,
    input  wire hist_pkg::cfg_addr_e    cfg_addr,
    input  wire logic [15:0]            cfg_data,
    output logic                        cfg_ack,
    // readout port, four-phase
    output logic                        rd_req,
    input  wire logic                   rd_ack,
    output hist_pkg::pixel_idx_t        rd_pixel,
    output hist_pkg::bin_idx_t          rd_bin,
    output hist_pkg::bin_count_t        rd_count,
    output logic                        rd_bank,
    output logic                        frame_done
);

    // configuration toward the sequencer
    logic [7:0]  hits_per_pixel;
    logic [15:0] acq_target;

    // fill side
    logic                 inc_en;
    hist_pkg::hist_addr_t inc_addr;
    logic                 fill_bank;
    logic                 frame_full;

    // read side
    hist_pkg::hist_addr_t rd_addr;
    logic                 clr_en;
    logic                 readout_busy;
    hist_pkg::bin_count_t bank_count;

    hist_config_regs u_cfg (
        .clk            (clk),
        .combin_res     (combin_res),
        .cfg_req        (cfg_req),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .cfg_ack        (cfg_ack),
        .hits_per_pixel (hits_per_pixel),
        .acq_target     (acq_target)
    );

    hist_sequencer u_seq (
        .clk            (clk),
        .combin_res     (combin_res),
        .hit_valid      (hit_valid),
        .hit_bin        (hit_bin),
        .hit_ready      (hit_ready),
        .hits_per_pixel (hits_per_pixel),
        .acq_target     (acq_target),
        .readout_busy   (readout_busy),
        .inc_en         (inc_en),
        .inc_addr       (inc_addr),
        .fill_bank      (fill_bank),
        .frame_full     (frame_full)
    );

    hist_bank u_bank (
        .clk        (clk),
        .combin_res (combin_res),
        .inc_en     (inc_en),
        .inc_addr   (inc_addr),
        .fill_bank  (fill_bank),
        .rd_addr    (rd_addr),
        .clr_en     (clr_en),
        .rd_count   (bank_count)
    );

    hist_readout u_rdo (
        .clk          (clk),
        .combin_res   (combin_res),
        .frame_full   (frame_full),
        .rd_count_in  (bank_count),
        .rd_addr      (rd_addr),
        .clr_en       (clr_en),
        .readout_busy (readout_busy),
        .rd_req       (rd_req),
        .rd_ack       (rd_ack),
        .rd_pixel     (rd_pixel),
        .rd_bin       (rd_bin),
        .rd_count     (rd_count),
        .rd_bank      (rd_bank),
        .frame_done   (frame_done)
    );

endmodule

`default_nettype wire

//--- logic/hist_readout.sv
`timescale 1ns/1ps
`default_nettype none

module hist_readout (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    input  wire logic                   frame_full,
    input  wire hist_pkg::bin_count_t   rd_count_in,
    output hist_pkg::hist_addr_t        rd_addr,
    output logic                        clr_en,
    output logic                        readout_busy,
    output logic                        rd_req,
    input  wire logic                   rd_ack,
    output hist_pkg::pixel_idx_t        rd_pixel,
    output hist_pkg::bin_idx_t          rd_bin,
    output hist_pkg::bin_count_t        rd_count,
    output logic                        rd_bank,
    output logic                        frame_done
);

    // start is a one cycle setup before the first request
    typedef enum logic [1:0] {
        R_IDLE  = 2'd0,
        R_START = 2'd1,
        R_REQ   = 2'd2,
        R_DROP  = 2'd3
    } rdo_state_t;

    rdo_state_t           state;
    hist_pkg::hist_addr_t addr_q;
    logic                 pend_q;
    logic                 bank_q;
    logic                 last_item;

    assign last_item = (addr_q == hist_pkg::hist_addr_t'(hist_pkg::HIST_WORDS - 1));

    // presented item, pixel in the upper address bits
    assign rd_addr  = addr_q;
    assign rd_pixel = addr_q[$bits(hist_pkg::hist_addr_t)-1 -: $bits(hist_pkg::pixel_idx_t)];
    assign rd_bin   = addr_q[$bits(hist_pkg::bin_idx_t)-1:0];
    assign rd_count = rd_count_in;
    assign rd_bank  = bank_q;

    assign rd_req       = (state == R_REQ);
    assign readout_busy = (state != R_IDLE);

    // bin cleared on the edge where req falls
    assign clr_en = (state == R_REQ) & rd_ack;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= R_IDLE;
            addr_q     <= '0;
            pend_q     <= 1'b0;
            bank_q     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            // remember one finished bank while busy
            if (frame_full && state != R_IDLE) begin
                pend_q <= 1'b1;
            end
            case (state)
                R_IDLE: begin
                    if (frame_full || pend_q) begin
                        state  <= R_START;
                        addr_q <= '0;
                        pend_q <= 1'b0;
                    end
                end
                R_START: state <= R_REQ;
                R_REQ: begin
                    if (rd_ack) begin
                        state <= R_DROP;
                    end
                end
                R_DROP: begin
                    // sink released ack, next item or end of bank
                    if (!rd_ack) begin
                        if (last_item) begin
                            state      <= R_IDLE;
                            frame_done <= 1'b1;
                            bank_q     <= ~bank_q;
                        end else begin
                            state  <= R_REQ;
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/hist_bank.sv
`timescale 1ns/1ps
`default_nettype none

module hist_bank (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    input  wire logic                   inc_en,
    input  wire hist_pkg::hist_addr_t   inc_addr,
    input  wire logic                   fill_bank,
    input  wire hist_pkg::hist_addr_t   rd_addr,
    input  wire logic                   clr_en,
    output hist_pkg::bin_count_t        rd_count
);

    // two banks back to back, bank select is the top address bit
    localparam int unsigned DEPTH = 2 * hist_pkg::HIST_WORDS;

    hist_pkg::bin_count_t mem [DEPTH];

    // full word addresses for the two paths
    logic [$bits(hist_pkg::hist_addr_t):0] inc_word;
    logic [$bits(hist_pkg::hist_addr_t):0] rd_word;

    hist_pkg::bin_count_t inc_old;
    hist_pkg::bin_count_t inc_new;

    // fill side writes its own bank
    assign inc_word = {fill_bank, inc_addr};

    // readout always looks at the bank not being filled
    assign rd_word = {~fill_bank, rd_addr};

    // saturating increment
    assign inc_old = mem[inc_word];
    assign inc_new = (inc_old == hist_pkg::COUNT_MAX) ? inc_old : inc_old + 1'b1;

    // combinational read, held stable by the readout address
    assign rd_count = mem[rd_word];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            // whole array starts empty
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // the two paths never touch the same bank
            if (inc_en) begin
                mem[inc_word] <= inc_new;
            end
            // clear on read, the bank is empty when it is filled again
            if (clr_en) begin
                mem[rd_word] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/hist_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_cfg.svh"

module hist_sequencer (
    input  wire logic                 clk,
    input  wire logic                 combin_res,
    input  wire logic                 hit_valid,
    input  wire hist_pkg::bin_idx_t   hit_bin,
    output logic                      hit_ready,
    input  wire logic [7:0]           hits_per_pixel,
    input  wire logic [15:0]          acq_target,
    input  wire logic                 readout_busy,
    output logic                      inc_en,
    output hist_pkg::hist_addr_t      inc_addr,
    output logic                      fill_bank,
    output logic                      frame_full
);

    // nested counters, hits inside pixel inside acquisition
    logic [7:0]           hit_cnt;
    hist_pkg::pixel_idx_t pix_cnt;
    logic [15:0]          acq_cnt;

    // bank being filled, and a frame waiting for the readout to free its bank
    logic fill_q;
    logic stall_q;

    logic accept;
    logic last_hit;
    logic last_pix;
    logic last_acq;
    logic frame_end;
    logic swap_now;

    assign accept = hit_valid & hit_ready;

    // a target of zero behaves like one
    assign last_hit = ({1'b0, hit_cnt} + 9'd1) >= {1'b0, hits_per_pixel};
    assign last_pix = (pix_cnt == hist_pkg::pixel_idx_t'(`HIST_PIXELS - 1));
    assign last_acq = ({1'b0, acq_cnt} + 17'd1) >= {1'b0, acq_target};

    assign frame_end = accept & last_hit & last_pix & last_acq;

    // previous readout just ended, the stalled frame hands its bank over now
    assign swap_now = stall_q & ~readout_busy;

    // during the swap cycle hits already go to the freshly cleared bank
    assign fill_bank = fill_q ^ swap_now;

    // stalled only while the readout still owns the other bank
    assign hit_ready = ~(stall_q & readout_busy);

    // word address is current pixel and the hit's bin
    assign inc_en   = accept;
    assign inc_addr = {pix_cnt, hit_bin};

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt    <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            fill_q     <= 1'b0;
            stall_q    <= 1'b0;
            frame_full <= 1'b0;
        end else begin
            // one cycle pulse toward the readout
            frame_full <= frame_end;
            if (swap_now) begin
                fill_q  <= ~fill_q;
                stall_q <= 1'b0;
            end
            if (accept) begin
                if (!last_hit) begin
                    hit_cnt <= hit_cnt + 8'd1;
                end else begin
                    hit_cnt <= '0;
                    if (!last_pix) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        acq_cnt <= last_acq ? 16'd0 : acq_cnt + 16'd1;
                    end
                end
            end
            // frame complete, switch now or hold hits until the bank frees
            if (frame_end) begin
                if (readout_busy) begin
                    stall_q <= 1'b1;
                end else begin
                    fill_q <= ~fill_q;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/hist_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_cfg.svh"

module hist_config_regs (
    input  wire logic                clk,
    input  wire logic                combin_res,
    input  wire logic                cfg_req,
    input  wire hist_pkg::cfg_addr_e cfg_addr,
    input  wire logic [15:0]         cfg_data,
    output logic                     cfg_ack,
    output logic [7:0]               hits_per_pixel,
    output logic [15:0]              acq_target
);

    // four-phase slave, idle or acknowledging
    typedef enum logic {
        C_IDLE = 1'b0,
        C_ACK  = 1'b1
    } cfg_state_t;

    cfg_state_t state;

    // ack is the state bit itself, so it is a clean register output
    assign cfg_ack = (state == C_ACK);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state          <= C_IDLE;
            hits_per_pixel <= 8'(`HIST_HITS_DEFAULT);
            acq_target     <= 16'(`HIST_ACQ_DEFAULT);
        end else begin
            case (state)
                C_IDLE: begin
                    // request seen, write once and raise ack on this edge
                    if (cfg_req) begin
                        state <= C_ACK;
                        case (cfg_addr)
                            hist_pkg::CFG_HITS: hits_per_pixel <= cfg_data[7:0];
                            hist_pkg::CFG_ACQ:  acq_target     <= cfg_data;
                            default:            acq_target     <= acq_target;
                        endcase
                    end
                end
                C_ACK: begin
                    // host released req, drop ack one cycle later
                    if (!cfg_req) begin
                        state <= C_IDLE;
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/hist_pkg.sv
`default_nettype none

`include "hist_cfg.svh"

package hist_pkg;

    // words in one bank, pixel major
    localparam int unsigned HIST_WORDS = `HIST_BINS * `HIST_PIXELS;

    // time bin index carried by a hit
    typedef logic [$clog2(`HIST_BINS)-1:0] bin_idx_t;

    // pixel index inside a frame
    typedef logic [$clog2(`HIST_PIXELS)-1:0] pixel_idx_t;

    // one histogram bin
    typedef logic [`HIST_COUNT_W-1:0] bin_count_t;

    // saturation value of a bin
    localparam bin_count_t COUNT_MAX = '1;

    // word address inside one bank
    // pixel in the upper bits, bin in the lower bits
    typedef logic [$clog2(HIST_WORDS)-1:0] hist_addr_t;

    // configuration register select
    // CFG_HITS is the 8 bit hits per pixel register
    // CFG_ACQ is the 16 bit acquisition target
    typedef enum logic {
        CFG_HITS = 1'b0,
        CFG_ACQ  = 1'b1
    } cfg_addr_e;

endpackage

`default_nettype wire

//--- logic/hist_cfg.svh
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// histogram geometry
// time bins per pixel, a power of two so the word address packs cleanly
`define HIST_BINS 16

// pixels per frame, also a power of two
`define HIST_PIXELS 4

// one bin count, saturates at all ones
`define HIST_COUNT_W 8

// configuration register defaults after reset
// hits per pixel before moving to the next pixel
`define HIST_HITS_DEFAULT 2

// acquisitions over all pixels per frame
`define HIST_ACQ_DEFAULT 2

`endif
